//--- vectorPkg.sv
// vertex word format shared by the sprite ROM, the display-list RAM and the testbench
package vectorPkg;

    //////////////////////////////////////////////////////////////////////
    // screen coordinates
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0] coordT;  // 0..255, sums wrap modulo 256

    //////////////////////////////////////////////////////////////////////
    // 18-bit vertex word, same layout in ROM and RAM
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        coordT x;     // bits 17:10
        coordT y;     // bits 9:2
        logic  line;  // draw a line to this point
        logic  pos;   // move the beam to this point
    } vertexT;

    // line and pos both set marks end of sprite in ROM, end of list in RAM

    // list opener, beam parked at bottom left
    localparam vertexT ORIGIN_WORD = '{x: 8'd0, y: 8'd0, line: 1'b0, pos: 1'b1};

    // list terminator for the line drawer
    localparam vertexT TERM_WORD = '{x: 8'd0, y: 8'd0, line: 1'b1, pos: 1'b1};

endpackage

//--- scenePkg.sv
// scene layout for the display-list composer: drawing order, sprite ROM map, anchors, cities
package scenePkg;

    import vectorPkg::*;

    //////////////////////////////////////////////////////////////////////
    // drawing order, one object per LOAD
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OBJ_FRAME  = 4'd0,  // screen border, static
        OBJ_MAP    = 4'd1,  // background map, static
        OBJ_CURSOR = 4'd2,
        OBJ_ENEMY0 = 4'd3,
        OBJ_ENEMY1 = 4'd4,
        OBJ_ENEMY2 = 4'd5,
        OBJ_CITY0  = 4'd6,
        OBJ_CITY1  = 4'd7,
        OBJ_CITY2  = 4'd8   // last object of the frame
    } objIdT;

    localparam int OBJ_COUNT   = 9;
    localparam int ENEMY_COUNT = 3;
    localparam int CITY_COUNT  = 3;

    //////////////////////////////////////////////////////////////////////
    // sprite ROM start addresses
    //////////////////////////////////////////////////////////////////////

    localparam logic [11:0] ADDR_FRAME  = 12'h000;
    localparam logic [11:0] ADDR_MAP    = 12'h040;
    localparam logic [11:0] ADDR_CURSOR = 12'h200;
    localparam logic [11:0] ADDR_ENEMY  = 12'h240;  // one sprite for all enemies
    localparam logic [11:0] ADDR_CITY   = 12'h280;
    localparam logic [11:0] ADDR_NUKE   = 12'h2C0;  // replaces a destroyed city

    //////////////////////////////////////////////////////////////////////
    // sprite anchors, the point that lands on the object position
    //////////////////////////////////////////////////////////////////////

    localparam coordT CURSOR_MID_X = 8'd4;
    localparam coordT CURSOR_MID_Y = 8'd4;
    localparam coordT ENEMY_MID_X  = 8'd6;
    localparam coordT ENEMY_MID_Y  = 8'd5;
    localparam coordT CITY_MID_X   = 8'd12;
    localparam coordT CITY_MID_Y   = 8'd3;
    localparam coordT NUKE_MID_X   = 8'd10;
    localparam coordT NUKE_MID_Y   = 8'd8;

    //////////////////////////////////////////////////////////////////////
    // fixed city positions along the ground
    //////////////////////////////////////////////////////////////////////

    localparam coordT CITY_X [CITY_COUNT] = '{8'd48, 8'd128, 8'd208};
    localparam coordT CITY_Y [CITY_COUNT] = '{8'd20, 8'd24, 8'd20};

endpackage

//--- vertexBus.sv
// beat channel from the sprite fetch sequencer to the display-list writer, no back-pressure
`timescale 1ns/1ns

interface vertexBus
    import vectorPkg::*;
    ();

    logic   valid;    // one beat, always taken
    logic   literal;  // write word as is, no translation
    vertexT word;     // raw ROM word or origin/terminator

    // sequencer side
    modport fetch (
        output valid,
        output literal,
        output word
    );

    // writer side
    modport sink (
        input valid,
        input literal,
        input word
    );

endinterface

//--- placeBus.sv
// placement of the current object, answered by the placement unit for the sequencer's object
`timescale 1ns/1ns

interface placeBus
    import vectorPkg::*, scenePkg::*;
    #(parameter int romAddrWidth = 12)
    ();

    objIdT                   obj;        // driven by the sequencer
    logic [romAddrWidth-1:0] startAddr;  // first ROM word of the sprite
    logic                    active;     // low for an enemy not yet spawned
    coordT                   offsetX;    // position minus anchor
    coordT                   offsetY;

    modport source (
        input  obj,
        output startAddr, active, offsetX, offsetY
    );

    modport seq (
        output obj,
        input  startAddr, active
    );

    modport writer (
        input offsetX, offsetY
    );

endinterface

//--- spriteFetchSeq.sv
// frame FSM walking objects and sprite ROM words, sending beats and running the go/drawBusy handshake
`timescale 1ns/1ns

module spriteFetchSeq
    import vectorPkg::*, scenePkg::*;
    #(parameter int romAddrWidth = 12) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    drawBusy,  // line drawer working on the list
    input  vertexT                  romData,   // combinational from romAddr
    output logic                    go,        // list ready for the line drawer
    output logic [romAddrWidth-1:0] romAddr,
    output logic                    frameStart,
    vertexBus.fetch                 vtx,
    placeBus.seq                    place
);

    typedef enum logic [2:0] {
        ST_START,  // origin beat and snapshot pulse
        ST_LOAD,   // pick sprite for current object
        ST_DRAW,   // one ROM word per cycle
        ST_CLOSE,  // terminator beat
        ST_DONE,   // wait for drawer idle
        ST_WAIT    // wait for drawer to pick up the list
    } stateT;

    stateT state;
    objIdT obj;
    logic  endMarker;
    logic  lastObj;

    assign endMarker = romData.line & romData.pos;
    assign lastObj   = (obj == OBJ_CITY2);

    assign place.obj  = obj;
    assign frameStart = (state == ST_START);
    assign go         = (state == ST_DONE) || (state == ST_WAIT);

    //////////////////////////////////////////////////////////////////////
    // state, object index and ROM address
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_START;
            obj     <= OBJ_FRAME;
            romAddr <= '0;
        end else begin
            case (state)
                ST_START: begin
                    obj   <= OBJ_FRAME;
                    state <= ST_LOAD;
                end
                ST_LOAD: begin
                    if (place.active) begin
                        romAddr <= place.startAddr;  // sprite read starts next cycle
                        state   <= ST_DRAW;
                    end else if (lastObj) begin
                        state <= ST_CLOSE;
                    end else begin
                        obj <= objIdT'(obj + 4'd1);  // skip unspawned enemy
                    end
                end
                ST_DRAW: begin
                    if (!endMarker) begin
                        romAddr <= romAddr + 1'b1;
                    end else if (lastObj) begin
                        state <= ST_CLOSE;
                    end else begin
                        obj   <= objIdT'(obj + 4'd1);
                        state <= ST_LOAD;
                    end
                end
                ST_CLOSE: state <= ST_DONE;
                ST_DONE: begin
                    if (!drawBusy) state <= ST_WAIT;  // drawer idle
                end
                ST_WAIT: begin
                    if (drawBusy) state <= ST_START;  // list taken
                end
                default: state <= ST_START;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // beats toward the writer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        vtx.valid   = 1'b0;
        vtx.literal = 1'b0;
        vtx.word    = romData;
        case (state)
            ST_START: begin
                vtx.valid   = 1'b1;
                vtx.literal = 1'b1;
                vtx.word    = ORIGIN_WORD;
            end
            ST_DRAW:  vtx.valid = !endMarker;  // end marker never written
            ST_CLOSE: begin
                vtx.valid   = 1'b1;
                vtx.literal = 1'b1;
                vtx.word    = TERM_WORD;
            end
            default: ;
        endcase
    end

    // list handed over only once the terminator has gone out
    assert property (@(posedge clk) disable iff (rst)
        $rose(go) |-> $past(vtx.valid && vtx.literal && (vtx.word == TERM_WORD)));

endmodule

//--- objectPlacement.sv
// per-frame snapshot of object positions; gives sprite address, offset and active flag
`timescale 1ns/1ns

module objectPlacement
    import vectorPkg::*, scenePkg::*;
    #(parameter int romAddrWidth = 12) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frameStart,  // from the sequencer in START
    input  coordT                  cursorX,
    input  coordT                  cursorY,
    input  coordT                  enemyX [ENEMY_COUNT],
    input  coordT                  enemyY [ENEMY_COUNT],
    input  logic [ENEMY_COUNT-1:0] enemySpawn,
    input  logic [CITY_COUNT-1:0]  cityNuked,
    placeBus.source                place
);

    coordT                  cursorXSnap;
    coordT                  cursorYSnap;
    coordT                  enemyXSnap [ENEMY_COUNT];
    coordT                  enemyYSnap [ENEMY_COUNT];
    logic [ENEMY_COUNT-1:0] spawnSnap;
    logic [CITY_COUNT-1:0]  nukedSnap;

    //////////////////////////////////////////////////////////////////////
    // snapshot, one consistent scene per frame
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            spawnSnap <= '0;
            nukedSnap <= '0;
        end else if (frameStart) begin
            spawnSnap <= enemySpawn;
            nukedSnap <= cityNuked;
        end
    end

    always_ff @(posedge clk) begin
        if (frameStart) begin
            cursorXSnap <= cursorX;
            cursorYSnap <= cursorY;
            enemyXSnap  <= enemyX;
            enemyYSnap  <= enemyY;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // address, offset and active rules
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        place.startAddr = romAddrWidth'(ADDR_FRAME);
        place.active    = 1'b1;   // only enemies can be inactive
        place.offsetX   = 8'd0;   // static sprites stay put
        place.offsetY   = 8'd0;
        case (place.obj)
            OBJ_MAP: place.startAddr = romAddrWidth'(ADDR_MAP);
            OBJ_CURSOR: begin
                place.startAddr = romAddrWidth'(ADDR_CURSOR);
                place.offsetX   = cursorXSnap - CURSOR_MID_X;
                place.offsetY   = cursorYSnap - CURSOR_MID_Y;
            end
            default: ;
        endcase
        for (int k = 0; k < ENEMY_COUNT; k++) begin
            if (place.obj == objIdT'(OBJ_ENEMY0 + k)) begin
                place.startAddr = romAddrWidth'(ADDR_ENEMY);  // shared sprite
                place.active    = spawnSnap[k];
                place.offsetX   = enemyXSnap[k] - ENEMY_MID_X;
                place.offsetY   = enemyYSnap[k] - ENEMY_MID_Y;
            end
        end
        for (int k = 0; k < CITY_COUNT; k++) begin
            if (place.obj == objIdT'(OBJ_CITY0 + k)) begin
                if (nukedSnap[k]) begin  // crater sprite with its own anchor
                    place.startAddr = romAddrWidth'(ADDR_NUKE);
                    place.offsetX   = CITY_X[k] - NUKE_MID_X;
                    place.offsetY   = CITY_Y[k] - NUKE_MID_Y;
                end else begin
                    place.startAddr = romAddrWidth'(ADDR_CITY);
                    place.offsetX   = CITY_X[k] - CITY_MID_X;
                    place.offsetY   = CITY_Y[k] - CITY_MID_Y;
                end
            end
        end
    end

    // sequencer must never step past the last object
    assert property (@(posedge clk) disable iff (rst) place.obj < OBJ_COUNT);

endmodule

//--- displayListWriter.sv
// moves fetched vertices by the object offset and writes them into the display-list RAM
`timescale 1ns/1ns

module displayListWriter
    import vectorPkg::*;
    #(parameter int listAddrWidth = 10) (
    input  logic                     clk,
    input  logic                     rst,
    vertexBus.sink                   vtx,
    placeBus.writer                  place,
    output logic                     ramWrite,  // one pulse per beat
    output logic [listAddrWidth-1:0] ramAddr,
    output vertexT                   ramData
);

    logic   originBeat;
    vertexT movedWord;

    // origin opens a new list at address 0
    assign originBeat = vtx.valid && vtx.literal && (vtx.word == ORIGIN_WORD);

    //////////////////////////////////////////////////////////////////////
    // translation wrapping modulo 256
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        movedWord      = vtx.word;  // line and pos kept
        movedWord.x    = vtx.word.x + place.offsetX;
        movedWord.y    = vtx.word.y + place.offsetY;
    end

    //////////////////////////////////////////////////////////////////////
    // write strobe and address counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ramWrite <= 1'b0;
            ramAddr  <= '0;
        end else begin
            ramWrite <= vtx.valid;
            if (originBeat) begin
                ramAddr <= '0;
            end else if (vtx.valid) begin
                ramAddr <= ramAddr + 1'b1;
            end
        end
    end

    // data word that goes with the strobe
    always_ff @(posedge clk) begin
        if (vtx.valid) begin
            ramData <= vtx.literal ? vtx.word : movedWord;
        end
    end

    // list must fit the RAM without wrapping past the top
    assert property (@(posedge clk) disable iff (rst)
        (vtx.valid && !originBeat) |-> (ramAddr != '1));

endmodule

//--- sceneComposer.sv
// display-list composer top: sprite ROM in, translated list into RAM, go/drawBusy to the drawer
`timescale 1ns/1ns

module sceneComposer
    import vectorPkg::*, scenePkg::*;
    #(
    parameter int romAddrWidth  = 12,
    parameter int listAddrWidth = 10
    ) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     drawBusy,
    output logic [romAddrWidth-1:0]  romAddr,
    input  vertexT                   romData,
    input  coordT                    cursorX,
    input  coordT                    cursorY,
    input  coordT                    enemyX [ENEMY_COUNT],
    input  coordT                    enemyY [ENEMY_COUNT],
    input  logic [ENEMY_COUNT-1:0]   enemySpawn,
    input  logic [CITY_COUNT-1:0]    cityNuked,
    output logic                     go,
    output logic                     ramWrite,
    output logic [listAddrWidth-1:0] ramAddr,
    output vertexT                   ramData
);

    logic frameStart;  // snapshot strobe

    vertexBus i_vtxBus ();
    placeBus #(.romAddrWidth(romAddrWidth)) i_placeBus ();

    //////////////////////////////////////////////////////////////////////
    // fetch, placement and write units
    //////////////////////////////////////////////////////////////////////

    spriteFetchSeq #(.romAddrWidth(romAddrWidth)) i_fetchSeq (
        .clk        (clk),
        .rst        (rst),
        .drawBusy   (drawBusy),
        .romData    (romData),
        .go         (go),
        .romAddr    (romAddr),
        .frameStart (frameStart),
        .vtx        (i_vtxBus.fetch),
        .place      (i_placeBus.seq)
    );

    objectPlacement #(.romAddrWidth(romAddrWidth)) i_placement (
        .clk        (clk),
        .rst        (rst),
        .frameStart (frameStart),
        .cursorX    (cursorX),
        .cursorY    (cursorY),
        .enemyX     (enemyX),
        .enemyY     (enemyY),
        .enemySpawn (enemySpawn),
        .cityNuked  (cityNuked),
        .place      (i_placeBus.source)
    );

    displayListWriter #(.listAddrWidth(listAddrWidth)) i_writer (
        .clk      (clk),
        .rst      (rst),
        .vtx      (i_vtxBus.sink),
        .place    (i_placeBus.writer),
        .ramWrite (ramWrite),
        .ramAddr  (ramAddr),
        .ramData  (ramData)
    );

endmodule

//--- sceneComposerTb.sv
// self-checking testbench for sceneComposer with random sprites and scenes against a list model
`timescale 1ns/1ns

module sceneComposerTb
    import vectorPkg::*, scenePkg::*;
    ();

    localparam int ROM_AW      = 12;
    localparam int LIST_AW     = 10;
    localparam int RST_CYCLES  = 4;
    localparam int NUM_FRAMES  = 8;
    localparam int MAX_SPRITE  = 7;  // 6 words plus end marker
    localparam int MAX_WORDS   = OBJ_COUNT * MAX_SPRITE;
    localparam int CYCLE_LIMIT = RST_CYCLES + NUM_FRAMES * (2 + OBJ_COUNT + MAX_WORDS + 20);

    logic                   clk;
    logic                   rst;
    logic                   drawBusy;
    logic [ROM_AW-1:0]      romAddr;
    vertexT                 romData;
    coordT                  cursorX;
    coordT                  cursorY;
    coordT                  enemyX [ENEMY_COUNT];
    coordT                  enemyY [ENEMY_COUNT];
    logic [ENEMY_COUNT-1:0] enemySpawn;
    logic [CITY_COUNT-1:0]  cityNuked;
    logic                   go;
    logic                   ramWrite;
    logic [LIST_AW-1:0]     ramAddr;
    vertexT                 ramData;

    vertexT             rom [0:(1<<ROM_AW)-1];  // sprite ROM model
    vertexT             expWords [$];           // list still to be written this frame
    logic [LIST_AW-1:0] expAddr;
    logic [31:0]        rngState;
    int                 wordsSeen;
    int                 testErrors;
    int                 passedTests;
    int                 failedTests;
    int                 checkCount;
    int                 cycleCount;
    string              testName;

    assign romData = rom[romAddr];  // combinational read

    sceneComposer #(.romAddrWidth(ROM_AW), .listAddrWidth(LIST_AW)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .drawBusy   (drawBusy),
        .romAddr    (romAddr),
        .romData    (romData),
        .cursorX    (cursorX),
        .cursorY    (cursorY),
        .enemyX     (enemyX),
        .enemyY     (enemyY),
        .enemySpawn (enemySpawn),
        .cityNuked  (cityNuked),
        .go         (go),
        .ramWrite   (ramWrite),
        .ramAddr    (ramAddr),
        .ramData    (ramData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop sized for the longest possible frames
    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run still busy after %0d cycles", cycleCount);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // random numbers and stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic vertexT randomVertex();
        logic [31:0] r;
        logic [1:0]  kind;
        vertexT      v;
        r    = nextRand();
        kind = r[17:16];
        if (kind == 2'b11) kind = 2'b10;  // never an end marker
        v.x = r[7:0];
        v.y = r[15:8];
        {v.line, v.pos} = kind;
        return v;
    endfunction

    task automatic fillRom();
        logic [ROM_AW-1:0] base [6];
        logic [ROM_AW-1:0] a;
        int                len;
        vertexT            marker;
        for (int i = 0; i < (1 << ROM_AW); i++) begin
            rom[i[ROM_AW-1:0]] = vertexT'({i[ROM_AW-1:0], ~i[5:0]});  // unused space
        end
        base = '{ADDR_FRAME, ADDR_MAP, ADDR_CURSOR, ADDR_ENEMY, ADDR_CITY, ADDR_NUKE};
        foreach (base[s]) begin
            a   = base[s];
            len = 2 + int'(nextRand() % 5);
            for (int i = 0; i < len; i++) begin
                rom[a] = randomVertex();
                a      = a + 1'b1;
            end
            marker      = randomVertex();  // x and y of the marker are don't care
            marker.line = 1'b1;
            marker.pos  = 1'b1;
            rom[a]      = marker;
        end
    endtask

    task automatic randomizeScene();
        logic [31:0] r;
        r          = nextRand();
        cursorX    = r[7:0];
        cursorY    = r[15:8];
        enemySpawn = r[18:16];
        cityNuked  = r[21:19];
        for (int k = 0; k < ENEMY_COUNT; k++) begin
            r         = nextRand();
            enemyX[k] = r[7:0];
            enemyY[k] = r[15:8];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model of one display list
    //////////////////////////////////////////////////////////////////////

    task automatic pushSprite(input logic [ROM_AW-1:0] addr, input coordT dx, input coordT dy);
        vertexT w;
        w = rom[addr];
        while (!(w.line && w.pos)) begin  // end marker stays out of the list
            w.x = w.x + dx;
            w.y = w.y + dy;
            expWords.push_back(w);
            addr = addr + 1'b1;
            w    = rom[addr];
        end
    endtask

    task automatic newScene();
        randomizeScene();
        expWords.delete();
        expWords.push_back(ORIGIN_WORD);
        pushSprite(ADDR_FRAME, 8'd0, 8'd0);
        pushSprite(ADDR_MAP, 8'd0, 8'd0);
        pushSprite(ADDR_CURSOR, cursorX - CURSOR_MID_X, cursorY - CURSOR_MID_Y);
        for (int k = 0; k < ENEMY_COUNT; k++) begin
            if (enemySpawn[k]) begin
                pushSprite(ADDR_ENEMY, enemyX[k] - ENEMY_MID_X, enemyY[k] - ENEMY_MID_Y);
            end
        end
        for (int k = 0; k < CITY_COUNT; k++) begin
            if (cityNuked[k]) begin
                pushSprite(ADDR_NUKE, CITY_X[k] - NUKE_MID_X, CITY_Y[k] - NUKE_MID_Y);
            end else begin
                pushSprite(ADDR_CITY, CITY_X[k] - CITY_MID_X, CITY_Y[k] - CITY_MID_Y);
            end
        end
        expWords.push_back(TERM_WORD);
        expAddr   = '0;
        wordsSeen = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-cycle checking and test bookkeeping
    //////////////////////////////////////////////////////////////////////

    // one clock with outputs sampled at the falling edge
    task automatic stepCycle();
        vertexT expWord;
        @(negedge clk);
        if (ramWrite) begin
            checkCount++;
            assert (expWords.size() > 0) else begin
                $display("%s: RAM write at address %0d after the list was complete",
                         testName, ramAddr);
                testErrors++;
            end
            if (expWords.size() > 0) begin
                expWord = expWords.pop_front();
                assert (ramAddr === expAddr) else begin
                    $display("CHECK FAILED %s ramAddr: expected %0d, actual %0d",
                             testName, expAddr, ramAddr);
                    testErrors++;
                end
                assert (ramData === expWord) else begin
                    $display("CHECK FAILED %s word %0d: expected %h, actual %h",
                             testName, wordsSeen, expWord, ramData);
                    testErrors++;
                end
                expAddr = expAddr + 1'b1;
                wordsSeen++;
            end
        end
    endtask

    task automatic checkGo(input logic expGo, input string what);
        checkCount++;
        assert (go === expGo) else begin
            $display("CHECK FAILED %s go %s: expected %b, actual %b",
                     testName, what, expGo, go);
            testErrors++;
        end
    endtask

    task automatic closeTest();
        if (testErrors == 0) begin
            passedTests++;
            $display("%s: ok, %0d words", testName, wordsSeen);
        end else begin
            failedTests++;
            $display("%s: %0d errors", testName, testErrors);
        end
        testErrors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        drawBusy    = 1'b1;  // drawer still working on an older list
        rngState    = 32'd45291;
        testErrors  = 0;
        passedTests = 0;
        failedTests = 0;
        checkCount  = 0;
        fillRom();
        newScene();  // first frame's inputs held through START
        testName = "reset";
        repeat (RST_CYCLES) @(negedge clk);
        checkGo(1'b0, "after reset");
        checkCount++;
        assert (ramWrite === 1'b0) else begin
            $display("CHECK FAILED reset ramWrite: expected 0, actual %b", ramWrite);
            testErrors++;
        end
        closeTest();
        rst = 1'b0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            testName = $sformatf("frame%0d", f);
            if (f > 0) begin
                stepCycle();  // START after the drawer took the list
                checkGo(1'b0, "after drawBusy rose");
            end
            do stepCycle(); while (wordsSeen == 0);  // origin written
            randomizeScene();  // snapshot already taken
            while (!go) stepCycle();
            checkCount++;
            assert (expWords.size() == 0) else begin
                $display("%s: go rose with %0d list words never written",
                         testName, expWords.size());
                testErrors++;
            end
            checkCount++;
            assert (ramWrite === 1'b1) else begin
                $display("%s: go rose without the terminator written in the same cycle",
                         testName);
                testErrors++;
            end
            repeat (1 + int'(nextRand() % 3)) begin  // drawer still busy
                stepCycle();
                checkGo(1'b1, "while drawBusy high");
            end
            drawBusy = 1'b0;
            repeat (1 + int'(nextRand() % 3)) begin
                stepCycle();
                checkGo(1'b1, "while drawBusy low");
            end
            closeTest();
            if (f < NUM_FRAMES - 1) begin
                newScene();
                drawBusy = 1'b1;  // drawer picks up the list
            end
        end

        $display("%0d tests ok, %0d tests failed, %0d checks", passedTests, failedTests, checkCount);
        if (failedTests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sceneComposer.f
vectorPkg.sv
scenePkg.sv
vertexBus.sv
placeBus.sv
spriteFetchSeq.sv
objectPlacement.sv
displayListWriter.sv
sceneComposer.sv
sceneComposerTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the sceneComposer testbench with Verilator, run it and judge the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module sceneComposerTb \
    -f sceneComposer.f -o simTb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0
